// ==== hdl/pipe_consts.svh ====
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

`define PIPE_XLEN        32
`define PIPE_NREG        16
`define PIPE_RADDR_W     4

// instruction word layout
`define PIPE_OPC_MSB     31
`define PIPE_OPC_LSB     28
`define PIPE_RD_MSB      27
`define PIPE_RD_LSB      24
`define PIPE_RS1_MSB     23
`define PIPE_RS1_LSB     20
`define PIPE_RS2_MSB     19
`define PIPE_RS2_LSB     16
`define PIPE_IMM_W       16

`define PIPE_EXC_W       4
`define PIPE_EXC_NONE    4'd0
`define PIPE_EXC_ILLEGAL 4'd2

`endif

// ==== hdl/pipe_pkg.sv ====
`include "pipe_consts.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        OPC_NOP  = 4'd0,
        OPC_ADD  = 4'd1,
        OPC_SUB  = 4'd2,
        OPC_AND  = 4'd3,
        OPC_OR   = 4'd4,
        OPC_XOR  = 4'd5,
        OPC_SLL  = 4'd6,
        OPC_SRL  = 4'd7,
        OPC_ADDI = 4'd8,
        OPC_LUI  = 4'd9  // 10..15 unused, illegal
    } opcode_e;

    typedef enum logic {
        ST_RUN  = 1'b0,
        ST_TRAP = 1'b1
    } ctrl_state_e;

    typedef struct packed {
        logic                     valid;
        opcode_e                  op;
        logic [`PIPE_XLEN-1:0]    opa;
        logic [`PIPE_XLEN-1:0]    opb;      // rs2 value or immediate
        logic [`PIPE_RADDR_W-1:0] rs1_addr;
        logic [`PIPE_RADDR_W-1:0] rs2_addr;
        logic [`PIPE_RADDR_W-1:0] rd;
        logic                     wreg;
        logic [`PIPE_XLEN-1:0]    pc;
        logic                     excp;
        logic [`PIPE_EXC_W-1:0]   excp_code;
    } id_ex_t;

    typedef struct packed {
        logic                     valid;
        logic                     wreg;
        logic [`PIPE_RADDR_W-1:0] rd;
        logic [`PIPE_XLEN-1:0]    data;
        logic                     excp;
        logic [`PIPE_EXC_W-1:0]   excp_code;
        logic [`PIPE_XLEN-1:0]    pc;
    } wb_t;

endpackage

// ==== hdl/reg_file.sv ====
`include "pipe_consts.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  pipe_pkg::wb_t            wb_i,
    input  logic [`PIPE_RADDR_W-1:0] ra1_i,
    input  logic [`PIPE_RADDR_W-1:0] ra2_i,
    output logic [`PIPE_XLEN-1:0]    rd1_o,
    output logic [`PIPE_XLEN-1:0]    rd2_o
);

    logic [`PIPE_XLEN-1:0] regs [`PIPE_NREG];
    logic                  wr_en;

    assign wr_en = wb_i.valid & wb_i.wreg & (wb_i.rd != '0); // r0 never written

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through, so a reader in the write cycle sees the new value
    assign rd1_o = (ra1_i == '0) ? '0 :
                   (wr_en && wb_i.rd == ra1_i) ? wb_i.data : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 :
                   (wr_en && wb_i.rd == ra2_i) ? wb_i.data : regs[ra2_i];

endmodule

// ==== hdl/inst_decode.sv ====
`include "pipe_consts.svh"

module inst_decode (
    input  logic                     inst_valid_i,
    input  logic [`PIPE_XLEN-1:0]    inst_i,
    input  logic [`PIPE_XLEN-1:0]    pc_i,
    input  logic                     accept_i,
    output logic [`PIPE_RADDR_W-1:0] ra1_o,
    output logic [`PIPE_RADDR_W-1:0] ra2_o,
    input  logic [`PIPE_XLEN-1:0]    rd1_i,
    input  logic [`PIPE_XLEN-1:0]    rd2_i,
    output pipe_pkg::id_ex_t         dec_o
);

    logic [`PIPE_OPC_MSB-`PIPE_OPC_LSB:0] opc_raw;
    pipe_pkg::opcode_e                    opc;
    logic [`PIPE_RADDR_W-1:0]             rd;
    logic [`PIPE_IMM_W-1:0]               imm;
    logic [`PIPE_XLEN-1:0]                opb;
    logic                                 legal;
    logic                                 dec_valid;

    assign opc_raw   = inst_i[`PIPE_OPC_MSB:`PIPE_OPC_LSB];
    assign opc       = pipe_pkg::opcode_e'(opc_raw);
    assign rd        = inst_i[`PIPE_RD_MSB:`PIPE_RD_LSB];
    assign imm       = inst_i[`PIPE_IMM_W-1:0];
    assign ra1_o     = inst_i[`PIPE_RS1_MSB:`PIPE_RS1_LSB];
    assign ra2_o     = inst_i[`PIPE_RS2_MSB:`PIPE_RS2_LSB];
    assign dec_valid = inst_valid_i & accept_i; // offered but not taken stays out

    always_comb begin
        legal = 1'b1;
        opb   = rd2_i;
        case (opc)
            pipe_pkg::OPC_ADDI: opb = {{(`PIPE_XLEN-`PIPE_IMM_W){1'b0}}, imm};
            pipe_pkg::OPC_LUI:  opb = {imm, {(`PIPE_XLEN-`PIPE_IMM_W){1'b0}}};
            pipe_pkg::OPC_NOP,
            pipe_pkg::OPC_ADD,
            pipe_pkg::OPC_SUB,
            pipe_pkg::OPC_AND,
            pipe_pkg::OPC_OR,
            pipe_pkg::OPC_XOR,
            pipe_pkg::OPC_SLL,
            pipe_pkg::OPC_SRL:  opb = rd2_i;
            default:            legal = 1'b0; // unused opcode
        endcase
    end

    always_comb begin
        dec_o.valid     = dec_valid;
        dec_o.op        = opc;
        dec_o.opa       = rd1_i;
        dec_o.opb       = opb;
        dec_o.rs1_addr  = ra1_o;
        dec_o.rs2_addr  = ra2_o;
        dec_o.rd        = rd;
        dec_o.wreg      = legal && (opc != pipe_pkg::OPC_NOP) && (rd != '0);
        dec_o.pc        = pc_i;
        dec_o.excp      = dec_valid & ~legal;
        dec_o.excp_code = legal ? `PIPE_EXC_NONE : `PIPE_EXC_ILLEGAL;
    end

endmodule

// ==== hdl/id_ex_stage.sv ====
module id_ex_stage (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stall_i,
    input  logic             flush_i,
    input  pipe_pkg::id_ex_t dec_i,
    output pipe_pkg::id_ex_t ex_o,
    output logic             hazard_req_o
);

    logic uses_rs2;
    logic rs1_hit;
    logic rs2_hit;

    always_comb begin
        case (dec_i.op)
            pipe_pkg::OPC_ADD,
            pipe_pkg::OPC_SUB,
            pipe_pkg::OPC_AND,
            pipe_pkg::OPC_OR,
            pipe_pkg::OPC_XOR,
            pipe_pkg::OPC_SLL,
            pipe_pkg::OPC_SRL: uses_rs2 = 1'b1;
            default:           uses_rs2 = 1'b0;
        endcase
    end

    // checked on the offered word, ready itself depends on this
    assign rs1_hit      = dec_i.rs1_addr == ex_o.rd;
    assign rs2_hit      = uses_rs2 && (dec_i.rs2_addr == ex_o.rd);
    assign hazard_req_o = ex_o.valid && ex_o.wreg && (ex_o.rd != '0) && (rs1_hit || rs2_hit);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o <= '0;
        end else if (flush_i || stall_i) begin
            ex_o <= '0; // bubble
        end else begin
            ex_o <= dec_i;
        end
    end

endmodule

// ==== hdl/alu_exec.sv ====
`include "pipe_consts.svh"

module alu_exec (
    input  logic             clk,
    input  logic             arst_n_i,
    input  pipe_pkg::id_ex_t ex_i,
    output pipe_pkg::wb_t    wb_o
);

    logic [`PIPE_XLEN-1:0] result;
    logic [4:0]            shamt;

    assign shamt = ex_i.opb[4:0];

    always_comb begin
        case (ex_i.op)
            pipe_pkg::OPC_ADD,
            pipe_pkg::OPC_ADDI: result = ex_i.opa + ex_i.opb;
            pipe_pkg::OPC_SUB:  result = ex_i.opa - ex_i.opb;
            pipe_pkg::OPC_AND:  result = ex_i.opa & ex_i.opb;
            pipe_pkg::OPC_OR:   result = ex_i.opa | ex_i.opb;
            pipe_pkg::OPC_XOR:  result = ex_i.opa ^ ex_i.opb;
            pipe_pkg::OPC_SLL:  result = ex_i.opa << shamt;
            pipe_pkg::OPC_SRL:  result = ex_i.opa >> shamt;
            pipe_pkg::OPC_LUI:  result = ex_i.opb; // already shifted in decode
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o.valid     <= ex_i.valid;
            wb_o.wreg      <= ex_i.wreg;
            wb_o.rd        <= ex_i.rd;
            wb_o.data      <= result;
            wb_o.excp      <= ex_i.excp;
            wb_o.excp_code <= ex_i.excp_code;
            wb_o.pc        <= ex_i.pc;
        end
    end

endmodule

// ==== hdl/pipe_ctrl.sv ====
module pipe_ctrl (
    input  logic clk,
    input  logic arst_n_i,
    input  logic hazard_req_i,
    input  logic ex_excp_i,
    input  logic trap_ack_i,
    output logic stall_o,
    output logic flush_o,
    output logic ready_o
);

    pipe_pkg::ctrl_state_e state_q;
    pipe_pkg::ctrl_state_e state_d;

    assign flush_o = ex_excp_i;
    assign stall_o = hazard_req_i & ~flush_o; // flush wins
    assign ready_o = (state_q == pipe_pkg::ST_RUN) & ~stall_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            pipe_pkg::ST_RUN: begin
                if (flush_o) begin
                    state_d = pipe_pkg::ST_TRAP;
                end
            end
            pipe_pkg::ST_TRAP: begin
                if (trap_ack_i) begin
                    state_d = pipe_pkg::ST_RUN;
                end
            end
            default: state_d = pipe_pkg::ST_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= pipe_pkg::ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== hdl/int_pipe_top.sv ====
`include "pipe_consts.svh"

module int_pipe_top (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     inst_valid_i,
    input  logic [`PIPE_XLEN-1:0]    inst_i,
    input  logic [`PIPE_XLEN-1:0]    pc_i,
    output logic                     inst_ready_o,
    input  logic                     trap_ack_i,
    output logic                     wb_valid_o,
    output logic [`PIPE_RADDR_W-1:0] wb_rd_o,
    output logic [`PIPE_XLEN-1:0]    wb_data_o,
    output logic                     excp_o,
    output logic [`PIPE_XLEN-1:0]    excp_pc_o,
    output logic [`PIPE_EXC_W-1:0]   excp_code_o
);

    pipe_pkg::id_ex_t         dec;
    pipe_pkg::id_ex_t         ex;
    pipe_pkg::wb_t            wb;
    logic [`PIPE_RADDR_W-1:0] ra1;
    logic [`PIPE_RADDR_W-1:0] ra2;
    logic [`PIPE_XLEN-1:0]    rd1;
    logic [`PIPE_XLEN-1:0]    rd2;
    logic                     hazard_req;
    logic                     stall;
    logic                     flush;

    reg_file i_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (wb),
        .ra1_i    (ra1),
        .ra2_i    (ra2),
        .rd1_o    (rd1),
        .rd2_o    (rd2)
    );

    inst_decode i_inst_decode (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .accept_i     (inst_ready_o),
        .ra1_o        (ra1),
        .ra2_o        (ra2),
        .rd1_i        (rd1),
        .rd2_i        (rd2),
        .dec_o        (dec)
    );

    id_ex_stage i_id_ex_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall),
        .flush_i      (flush),
        .dec_i        (dec),
        .ex_o         (ex),
        .hazard_req_o (hazard_req)
    );

    alu_exec i_alu_exec (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .ex_i     (ex),
        .wb_o     (wb)
    );

    pipe_ctrl i_pipe_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .hazard_req_i (hazard_req),
        .ex_excp_i    (ex.excp),
        .trap_ack_i   (trap_ack_i),
        .stall_o      (stall),
        .flush_o      (flush),
        .ready_o      (inst_ready_o)
    );

    assign wb_valid_o  = wb.valid & wb.wreg;
    assign wb_rd_o     = wb.rd;
    assign wb_data_o   = wb.data;
    assign excp_o      = wb.valid & wb.excp;
    assign excp_pc_o   = wb.pc;
    assign excp_code_o = wb.excp_code;

endmodule

// ==== sim/clk_gen.sv ====
module clk_gen (
    output logic clk,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk);
        #2 arst_n_o = 1'b1; // released off the edge
    end

endmodule

// ==== sim/int_pipe_tb.sv ====
`include "pipe_consts.svh"

module int_pipe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_INST      = 300;
    localparam int CYCLE_LIMIT = 4 * N_INST + 200;

    logic                     clk;
    logic                     arst_n_i;
    logic                     inst_valid_i;
    logic [`PIPE_XLEN-1:0]    inst_i;
    logic [`PIPE_XLEN-1:0]    pc_i;
    logic                     inst_ready_o;
    logic                     trap_ack_i;
    logic                     wb_valid_o;
    logic [`PIPE_RADDR_W-1:0] wb_rd_o;
    logic [`PIPE_XLEN-1:0]    wb_data_o;
    logic                     excp_o;
    logic [`PIPE_XLEN-1:0]    excp_pc_o;
    logic [`PIPE_EXC_W-1:0]   excp_code_o;

    logic [`PIPE_XLEN-1:0]    ref_regs [`PIPE_NREG];
    pipe_pkg::wb_t            exp_ex; // expected contents of the ex slot
    pipe_pkg::wb_t            exp_wb;
    logic                     exp_ready;
    logic                     in_trap;
    int                       ack_wait;
    int                       offered;
    logic [`PIPE_XLEN-1:0]    next_pc;
    logic [31:0]              rng_state;
    int                       ready_errs;
    int                       wb_errs;
    int                       excp_errs;
    int                       cycle_cnt;

    clk_gen i_clk_gen (
        .clk      (clk),
        .arst_n_o (arst_n_i)
    );

    int_pipe_top i_int_pipe_top (.*);

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // three picks in four land on r0..r3
    function automatic logic [3:0] pick_reg(input logic [5:0] b);
        return (b[5:4] != 2'b11) ? {2'b00, b[1:0]} : b[3:0];
    endfunction

    function automatic logic [31:0] make_inst();
        logic [31:0] r;
        logic [31:0] w;
        r = next_rand();
        w = next_rand(); // low half stays as imm16
        w[`PIPE_OPC_MSB:`PIPE_OPC_LSB] = (r[3:0] == 4'd0) ? 4'd10 + r[7:4] % 4'd6
                                                          : r[11:8] % 4'd10;
        w[`PIPE_RD_MSB:`PIPE_RD_LSB]   = pick_reg(r[17:12]);
        w[`PIPE_RS1_MSB:`PIPE_RS1_LSB] = pick_reg(r[23:18]);
        w[`PIPE_RS2_MSB:`PIPE_RS2_LSB] = pick_reg(r[29:24]);
        return w;
    endfunction

    function automatic logic reads_pending_rd(input logic [31:0] w, input pipe_pkg::wb_t ahead);
        logic [3:0] opc;
        logic       reg_op;
        opc    = w[`PIPE_OPC_MSB:`PIPE_OPC_LSB];
        reg_op = (opc >= pipe_pkg::OPC_ADD) && (opc <= pipe_pkg::OPC_SRL);
        return ahead.valid && ahead.wreg && (ahead.rd != '0) &&
               ((w[`PIPE_RS1_MSB:`PIPE_RS1_LSB] == ahead.rd) ||
                (reg_op && (w[`PIPE_RS2_MSB:`PIPE_RS2_LSB] == ahead.rd)));
    endfunction

    // runs the offered word on the reference registers in program order
    task automatic execute_ref(output pipe_pkg::wb_t res);
        logic [3:0]             opc;
        logic [`PIPE_XLEN-1:0]  a;
        logic [`PIPE_XLEN-1:0]  b;
        logic [`PIPE_IMM_W-1:0] imm;
        opc       = inst_i[`PIPE_OPC_MSB:`PIPE_OPC_LSB];
        a         = ref_regs[inst_i[`PIPE_RS1_MSB:`PIPE_RS1_LSB]];
        b         = ref_regs[inst_i[`PIPE_RS2_MSB:`PIPE_RS2_LSB]];
        imm       = inst_i[`PIPE_IMM_W-1:0];
        res       = '0;
        res.valid = 1'b1;
        res.rd    = inst_i[`PIPE_RD_MSB:`PIPE_RD_LSB];
        res.pc    = pc_i;
        case (pipe_pkg::opcode_e'(opc))
            pipe_pkg::OPC_NOP:  res.data = '0;
            pipe_pkg::OPC_ADD:  res.data = a + b;
            pipe_pkg::OPC_SUB:  res.data = a - b;
            pipe_pkg::OPC_AND:  res.data = a & b;
            pipe_pkg::OPC_OR:   res.data = a | b;
            pipe_pkg::OPC_XOR:  res.data = a ^ b;
            pipe_pkg::OPC_SLL:  res.data = a << b[4:0];
            pipe_pkg::OPC_SRL:  res.data = a >> b[4:0];
            pipe_pkg::OPC_ADDI: res.data = a + {16'h0000, imm};
            pipe_pkg::OPC_LUI:  res.data = {imm, 16'h0000};
            default: begin
                res.excp      = 1'b1;
                res.excp_code = `PIPE_EXC_ILLEGAL;
            end
        endcase
        res.wreg = !res.excp && (opc != pipe_pkg::OPC_NOP) && (res.rd != '0);
        if (res.wreg) begin
            ref_regs[res.rd] = res.data; // r0 is never written
        end
    endtask

    task automatic advance_cycle();
        logic          accepted;
        logic          flush;
        pipe_pkg::wb_t issued;
        accepted = inst_valid_i && exp_ready;
        flush    = exp_ex.valid && exp_ex.excp;
        issued   = '0;
        if (in_trap) begin
            in_trap = !trap_ack_i;
        end else if (flush) begin
            in_trap  = 1'b1;
            ack_wait = int'(next_rand() % 32'd7);
        end
        if (accepted && !flush) begin // squashed behind an exception otherwise
            execute_ref(issued);
        end
        exp_wb     = exp_ex;
        exp_ex     = issued;
        trap_ack_i = in_trap && (ack_wait == 0);
        if (in_trap && ack_wait > 0) begin
            ack_wait--;
        end
        if (accepted || !inst_valid_i) begin
            inst_valid_i = 1'b0;
            inst_i       = '0;
            if (offered < N_INST && next_rand() % 32'd8 != 32'd0) begin
                inst_valid_i = 1'b1;
                inst_i       = make_inst();
                pc_i         = next_pc;
                next_pc      = next_pc + 32'd4;
                offered++;
            end
        end
        exp_ready = !in_trap && ((exp_ex.valid && exp_ex.excp) ||
                                 !(inst_valid_i && reads_pending_rd(inst_i, exp_ex)));
    endtask

    ready_check: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_ready_o == exp_ready)
        else begin
            ready_errs++;
            $display("ERR %0t: inst_ready_o differs from expected %0b", $time, exp_ready);
        end

    wb_check: assert property (@(posedge clk) disable iff (!arst_n_i)
        (exp_wb.valid && exp_wb.wreg) ?
            (wb_valid_o && wb_rd_o == exp_wb.rd && wb_data_o == exp_wb.data) : !wb_valid_o)
        else begin
            wb_errs++;
            $display("ERR %0t: write-back differs, expected valid %0b rd %0d data %h",
                     $time, exp_wb.valid && exp_wb.wreg, exp_wb.rd, exp_wb.data);
        end

    excp_check: assert property (@(posedge clk) disable iff (!arst_n_i)
        (exp_wb.valid && exp_wb.excp) ?
            (excp_o && excp_pc_o == exp_wb.pc && excp_code_o == exp_wb.excp_code) : !excp_o)
        else begin
            excp_errs++;
            $display("ERR %0t: exception differs, expected pulse %0b pc %h code %0d",
                     $time, exp_wb.valid && exp_wb.excp, exp_wb.pc, exp_wb.excp_code);
        end

    initial begin : stimulus
        int total;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        trap_ack_i   = 1'b0;
        ref_regs     = '{default: '0};
        exp_ex       = '0;
        exp_wb       = '0;
        exp_ready    = 1'b1;
        in_trap      = 1'b0;
        ack_wait     = 0;
        offered      = 0;
        next_pc      = 32'h0000_1000;
        rng_state    = 32'hd7d8_cf8a;
        ready_errs   = 0;
        wb_errs      = 0;
        excp_errs    = 0;
        @(posedge arst_n_i);
        while (offered < N_INST || inst_valid_i || exp_ex.valid || exp_wb.valid) begin
            @(posedge clk);
            #2;
            advance_cycle();
        end
        @(posedge clk); // last checks fire here
        #2;
        total = ready_errs + wb_errs + excp_errs;
        $display("errors: ready %0d, writeback %0d, exception %0d", ready_errs, wb_errs,
                 excp_errs);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/inst_decode.sv
hdl/id_ex_stage.sv
hdl/alu_exec.sv
hdl/pipe_ctrl.sv
hdl/int_pipe_top.sv
sim/clk_gen.sv
sim/int_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps --top-module int_pipe_tb \
    -f verilog.f -o int_pipe_sim &&
./obj_dir/int_pipe_sim | grep "Test completed successfully" ||
{ echo "simulation did not pass"; exit 1; }
